// ==== flist.f ====
rtl/rob_pkg.sv
rtl/dispatch_unit.sv
rtl/exec_unit.sv
rtl/rob.sv
rtl/commit_unit.sv
rtl/rob_core_top.sv
testbench/tb_rob_core.sv

// ==== rtl/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         head_ready_i,
    input  rob_pkg::op_class_e           head_cls_i,
    input  logic [4:0]                   head_rd_i,
    input  rob_pkg::rob_result_u         head_word_i,
    input  logic                         head_taken_i,
    input  logic [4:0]                   arch_raddr_i,
    output logic                         retire_o,
    output logic                         flush_o,
    output logic                         commit_valid_o,
    output logic [4:0]                   commit_rd_o,
    output logic [rob_pkg::XLEN-1:0]     commit_value_o,
    output logic                         redirect_o,
    output logic [rob_pkg::XLEN-1:0]     redirect_pc_o,
    output logic [rob_pkg::XLEN-1:0]     arch_rdata_o
);
    import rob_pkg::*;

    logic [XLEN-1:0] regs_q [32];
    logic            redirect_d;

    // pop whenever the head is ready, but not while flushing
    assign retire_o   = head_ready_i & ~flush_o;
    assign redirect_d = retire_o & (head_cls_i == CLS_BEQ) & head_taken_i;

    // x0 reads as zero
    assign arch_rdata_o = (arch_raddr_i == 5'd0) ? '0 : regs_q[arch_raddr_i];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            commit_valid_o <= 1'b0;
            redirect_o     <= 1'b0;
            flush_o        <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            commit_valid_o <= 1'b0;
            redirect_o     <= redirect_d;
            flush_o        <= redirect_d;
            // register writeback, rd 0 is silent
            if (retire_o && head_cls_i != CLS_BEQ && head_rd_i != 5'd0) begin
                regs_q[head_rd_i] <= head_word_i.value;
                commit_valid_o    <= 1'b1;
            end
        end
    end

    // reported values, qualified by the strobes above
    always_ff @(posedge clk) begin
        commit_rd_o    <= head_rd_i;
        commit_value_o <= head_word_i.value;
        redirect_pc_o  <= head_word_i.target_pc;
    end

endmodule

// ==== rtl/dispatch_unit.sv ====
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         flush_i,
    input  logic                         instr_valid_i,
    input  logic [31:0]                  instr_i,
    input  logic [rob_pkg::XLEN-1:0]     pc_i,
    input  logic [rob_pkg::XLEN-1:0]     src_a_i,
    input  logic [rob_pkg::XLEN-1:0]     src_b_i,
    input  logic                         rob_full_i,
    input  logic [rob_pkg::TAG_W-1:0]    free_tag_i,
    output logic                         stall_o,
    output logic                         alloc_valid_o,
    output logic [rob_pkg::TAG_W-1:0]    alloc_tag_o,
    output rob_pkg::op_class_e           alloc_cls_o,
    output logic [4:0]                   alloc_rd_o,
    output logic [rob_pkg::XLEN-1:0]     iss_a_o,
    output logic [rob_pkg::XLEN-1:0]     iss_b_o,
    output logic [rob_pkg::XLEN-1:0]     iss_imm_o,
    output logic [rob_pkg::XLEN-1:0]     iss_pc_o
);
    import rob_pkg::*;

    op_class_e       cls_d;
    logic [4:0]      rd_d;
    logic [XLEN-1:0] imm_d;
    logic            accept;

    // hold off while the buffer is near full or a flush is going out
    assign stall_o = rob_full_i | flush_i;
    assign accept  = instr_valid_i & ~stall_o;

    // opcode decode, anything unknown falls back to addi
    always_comb begin
        rd_d = instr_i[11:7];
        case (instr_i[6:0])
            OPC_LUI: begin
                cls_d = CLS_LUI;
                imm_d = {instr_i[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                cls_d = CLS_BEQ;
                // b-format, low bit always zero
                imm_d = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
                // no destination for a branch
                rd_d  = 5'd0;
            end
            default: begin
                cls_d = CLS_ADDI;
                imm_d = {{20{instr_i[31]}}, instr_i[31:20]};
            end
        endcase
    end

    // allocate and issue go out together from the same register
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            alloc_valid_o <= 1'b0;
        end else begin
            alloc_valid_o <= accept;
        end
        // payload only
        if (accept) begin
            alloc_tag_o <= free_tag_i;
            alloc_cls_o <= cls_d;
            alloc_rd_o  <= rd_d;
            iss_a_o     <= src_a_i;
            iss_b_o     <= src_b_i;
            iss_imm_o   <= imm_d;
            iss_pc_o    <= pc_i;
        end
    end

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         flush_i,
    input  logic                         iss_valid_i,
    input  logic [rob_pkg::TAG_W-1:0]    iss_tag_i,
    input  rob_pkg::op_class_e           iss_cls_i,
    input  logic [rob_pkg::XLEN-1:0]     iss_a_i,
    input  logic [rob_pkg::XLEN-1:0]     iss_b_i,
    input  logic [rob_pkg::XLEN-1:0]     iss_imm_i,
    input  logic [rob_pkg::XLEN-1:0]     iss_pc_i,
    output logic                         cdb0_valid_o,
    output logic [rob_pkg::TAG_W-1:0]    cdb0_tag_o,
    output rob_pkg::rob_result_u         cdb0_word_o,
    output logic                         cdb1_valid_o,
    output logic [rob_pkg::TAG_W-1:0]    cdb1_tag_o,
    output rob_pkg::rob_result_u         cdb1_word_o,
    output logic                         cdb1_taken_o
);
    import rob_pkg::*;

    logic            fast_go;
    logic            br_go;
    logic            br_taken_d;
    rob_result_u     br_word_d;

    // branch pipe, stage 0 is the compare
    logic            br_valid_q [BR_LAT];
    logic [TAG_W-1:0] br_tag_q  [BR_LAT];
    rob_result_u     br_word_q  [BR_LAT];
    logic            br_taken_q [BR_LAT];

    // nothing new enters while flushing
    assign fast_go = iss_valid_i & ~flush_i & (iss_cls_i != CLS_BEQ);
    assign br_go   = iss_valid_i & ~flush_i & (iss_cls_i == CLS_BEQ);

    // compare and target in the first stage
    always_comb begin
        br_taken_d          = (iss_a_i == iss_b_i);
        br_word_d.target_pc = br_taken_d ? (iss_pc_i + iss_imm_i) : (iss_pc_i + 32'd4);
    end

    // fast lane, single cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cdb0_valid_o <= 1'b0;
        end else begin
            cdb0_valid_o <= fast_go;
        end
        if (fast_go) begin
            cdb0_tag_o <= iss_tag_i;
            // lui just passes the u-immediate through
            if (iss_cls_i == CLS_LUI) begin
                cdb0_word_o.value <= iss_imm_i;
            end else begin
                cdb0_word_o.value <= iss_a_i + iss_imm_i;
            end
        end
    end

    // branch lane valid bits, killed on flush
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            for (int i = 0; i < BR_LAT; i++) begin
                br_valid_q[i] <= 1'b0;
            end
        end else begin
            br_valid_q[0] <= br_go;
            for (int i = 1; i < BR_LAT; i++) begin
                br_valid_q[i] <= br_valid_q[i-1];
            end
        end
    end

    // branch payload shift
    always_ff @(posedge clk) begin
        br_tag_q[0]   <= iss_tag_i;
        br_word_q[0]  <= br_word_d;
        br_taken_q[0] <= br_taken_d;
        for (int i = 1; i < BR_LAT; i++) begin
            br_tag_q[i]   <= br_tag_q[i-1];
            br_word_q[i]  <= br_word_q[i-1];
            br_taken_q[i] <= br_taken_q[i-1];
        end
    end

    // last stage drives lane 1
    assign cdb1_valid_o = br_valid_q[BR_LAT-1];
    assign cdb1_tag_o   = br_tag_q[BR_LAT-1];
    assign cdb1_word_o  = br_word_q[BR_LAT-1];
    assign cdb1_taken_o = br_taken_q[BR_LAT-1];

endmodule

// ==== rtl/rob.sv ====
`timescale 1ns/1ps

module rob (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         flush_i,
    input  logic                         alloc_valid_i,
    input  logic [rob_pkg::TAG_W-1:0]    alloc_tag_i,
    input  rob_pkg::op_class_e           alloc_cls_i,
    input  logic [4:0]                   alloc_rd_i,
    input  logic                         cdb0_valid_i,
    input  logic [rob_pkg::TAG_W-1:0]    cdb0_tag_i,
    input  rob_pkg::rob_result_u         cdb0_word_i,
    input  logic                         cdb1_valid_i,
    input  logic [rob_pkg::TAG_W-1:0]    cdb1_tag_i,
    input  rob_pkg::rob_result_u         cdb1_word_i,
    input  logic                         cdb1_taken_i,
    input  logic                         retire_i,
    output logic [rob_pkg::TAG_W-1:0]    free_tag_o,
    output logic                         rob_full_o,
    output logic                         head_ready_o,
    output rob_pkg::op_class_e           head_cls_o,
    output logic [4:0]                   head_rd_o,
    output rob_pkg::rob_result_u         head_word_o,
    output logic                         head_taken_o
);
    import rob_pkg::*;

    // control state per entry
    logic             valid_q [ROB_DEPTH];
    logic             done_q  [ROB_DEPTH];

    // payload per entry
    op_class_e        cls_q   [ROB_DEPTH];
    logic [4:0]       rd_q    [ROB_DEPTH];
    rob_result_u      word_q  [ROB_DEPTH];
    logic             taken_q [ROB_DEPTH];

    logic [TAG_W-1:0] head_q;
    logic [TAG_W-1:0] tail_q;
    logic [TAG_W:0]   count_q;

    // cdb lanes gathered for one capture loop
    logic             cdb_v   [NUM_CDB];
    logic [TAG_W-1:0] cdb_tag [NUM_CDB];
    rob_result_u      cdb_w   [NUM_CDB];
    logic             cdb_tk  [NUM_CDB];

    assign cdb_v[0]   = cdb0_valid_i;
    assign cdb_tag[0] = cdb0_tag_i;
    assign cdb_w[0]   = cdb0_word_i;
    // fast lane never branches
    assign cdb_tk[0]  = 1'b0;
    assign cdb_v[1]   = cdb1_valid_i;
    assign cdb_tag[1] = cdb1_tag_i;
    assign cdb_w[1]   = cdb1_word_i;
    assign cdb_tk[1]  = cdb1_taken_i;

    // next free slot, skipping the allocation still in flight
    assign free_tag_o = alloc_valid_i ? tail_q + 1'b1 : tail_q;

    // one slot held back for that same in-flight allocation
    assign rob_full_o = (count_q >= (TAG_W + 1)'(ROB_DEPTH - 1));

    // head presentation
    assign head_ready_o = valid_q[head_q] & done_q[head_q];
    assign head_cls_o   = cls_q[head_q];
    assign head_rd_o    = rd_q[head_q];
    assign head_word_o  = word_q[head_q];
    assign head_taken_o = taken_q[head_q];

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_valid_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_i) begin
                head_q <= head_q + 1'b1;
            end
            // alloc and retire in one cycle cancel out
            case ({alloc_valid_i, retire_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry valid and done bits
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
                done_q[i]  <= 1'b0;
            end
        end else begin
            // capture by tag, only into a waiting entry
            for (int l = 0; l < NUM_CDB; l++) begin
                if (cdb_v[l] && valid_q[cdb_tag[l]] && !done_q[cdb_tag[l]]) begin
                    done_q[cdb_tag[l]] <= 1'b1;
                end
            end
            if (retire_i) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
            end
            // new entry starts out waiting
            if (alloc_valid_i) begin
                valid_q[alloc_tag_i] <= 1'b1;
                done_q[alloc_tag_i]  <= 1'b0;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_valid_i) begin
            cls_q[alloc_tag_i] <= alloc_cls_i;
            rd_q[alloc_tag_i]  <= alloc_rd_i;
        end
        for (int l = 0; l < NUM_CDB; l++) begin
            if (cdb_v[l] && valid_q[cdb_tag[l]] && !done_q[cdb_tag[l]]) begin
                word_q[cdb_tag[l]]  <= cdb_w[l];
                taken_q[cdb_tag[l]] <= cdb_tk[l];
            end
        end
    end

endmodule

// ==== rtl/rob_core_top.sv ====
`timescale 1ns/1ps

module rob_core_top (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         instr_valid_i,
    input  logic [31:0]                  instr_i,
    input  logic [rob_pkg::XLEN-1:0]     pc_i,
    input  logic [rob_pkg::XLEN-1:0]     src_a_i,
    input  logic [rob_pkg::XLEN-1:0]     src_b_i,
    input  logic [4:0]                   arch_raddr_i,
    output logic                         stall_o,
    output logic                         commit_valid_o,
    output logic [4:0]                   commit_rd_o,
    output logic [rob_pkg::XLEN-1:0]     commit_value_o,
    output logic                         redirect_o,
    output logic [rob_pkg::XLEN-1:0]     redirect_pc_o,
    output logic [rob_pkg::XLEN-1:0]     arch_rdata_o
);
    import rob_pkg::*;

    // allocate / issue
    logic             alloc_valid;
    logic [TAG_W-1:0] alloc_tag;
    op_class_e        alloc_cls;
    logic [4:0]       alloc_rd;
    logic [XLEN-1:0]  iss_a;
    logic [XLEN-1:0]  iss_b;
    logic [XLEN-1:0]  iss_imm;
    logic [XLEN-1:0]  iss_pc;
    logic [TAG_W-1:0] free_tag;
    logic             rob_full;

    // cdb lanes
    logic             cdb0_valid;
    logic [TAG_W-1:0] cdb0_tag;
    rob_result_u      cdb0_word;
    logic             cdb1_valid;
    logic [TAG_W-1:0] cdb1_tag;
    rob_result_u      cdb1_word;
    logic             cdb1_taken;

    // head and retirement
    logic             head_ready;
    op_class_e        head_cls;
    logic [4:0]       head_rd;
    rob_result_u      head_word;
    logic             head_taken;
    logic             retire;
    logic             flush;

    dispatch_unit u_dispatch (
        .clk(clk), .rst_i(rst_i), .flush_i(flush),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .pc_i(pc_i),
        .src_a_i(src_a_i), .src_b_i(src_b_i),
        .rob_full_i(rob_full), .free_tag_i(free_tag), .stall_o(stall_o),
        .alloc_valid_o(alloc_valid), .alloc_tag_o(alloc_tag),
        .alloc_cls_o(alloc_cls), .alloc_rd_o(alloc_rd),
        .iss_a_o(iss_a), .iss_b_o(iss_b), .iss_imm_o(iss_imm), .iss_pc_o(iss_pc)
    );

    exec_unit u_exec (
        .clk(clk), .rst_i(rst_i), .flush_i(flush),
        .iss_valid_i(alloc_valid), .iss_tag_i(alloc_tag), .iss_cls_i(alloc_cls),
        .iss_a_i(iss_a), .iss_b_i(iss_b), .iss_imm_i(iss_imm), .iss_pc_i(iss_pc),
        .cdb0_valid_o(cdb0_valid), .cdb0_tag_o(cdb0_tag), .cdb0_word_o(cdb0_word),
        .cdb1_valid_o(cdb1_valid), .cdb1_tag_o(cdb1_tag), .cdb1_word_o(cdb1_word),
        .cdb1_taken_o(cdb1_taken)
    );

    rob u_rob (
        .clk(clk), .rst_i(rst_i), .flush_i(flush),
        .alloc_valid_i(alloc_valid), .alloc_tag_i(alloc_tag),
        .alloc_cls_i(alloc_cls), .alloc_rd_i(alloc_rd),
        .cdb0_valid_i(cdb0_valid), .cdb0_tag_i(cdb0_tag), .cdb0_word_i(cdb0_word),
        .cdb1_valid_i(cdb1_valid), .cdb1_tag_i(cdb1_tag), .cdb1_word_i(cdb1_word),
        .cdb1_taken_i(cdb1_taken), .retire_i(retire),
        .free_tag_o(free_tag), .rob_full_o(rob_full),
        .head_ready_o(head_ready), .head_cls_o(head_cls), .head_rd_o(head_rd),
        .head_word_o(head_word), .head_taken_o(head_taken)
    );

    commit_unit u_commit (
        .clk(clk), .rst_i(rst_i),
        .head_ready_i(head_ready), .head_cls_i(head_cls), .head_rd_i(head_rd),
        .head_word_i(head_word), .head_taken_i(head_taken),
        .arch_raddr_i(arch_raddr_i), .retire_o(retire), .flush_o(flush),
        .commit_valid_o(commit_valid_o), .commit_rd_o(commit_rd_o),
        .commit_value_o(commit_value_o), .redirect_o(redirect_o),
        .redirect_pc_o(redirect_pc_o), .arch_rdata_o(arch_rdata_o)
    );

endmodule

// ==== rtl/rob_pkg.sv ====
package rob_pkg;

    // reorder buffer sizing
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int XLEN      = 32;

    // cdb lanes, lane 0 fast alu, lane 1 branch
    localparam int NUM_CDB = 2;

    // stages in the branch lane
    localparam int BR_LAT = 3;

    // rv32i major opcodes in use
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // operation class carried from decode to retirement
    typedef enum logic [1:0] {
        CLS_ADDI = 2'd0,
        CLS_LUI  = 2'd1,
        CLS_BEQ  = 2'd2
    } op_class_e;

    // one result word, meaning depends on the class
    // value for addi and lui
    // target_pc for beq, taken or fall-through
    typedef union packed {
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] target_pc;
    } rob_result_u;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the reorder-buffer core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rob_core -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_rob_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0

// ==== testbench/tb_rob_core.sv ====
`timescale 1ns/1ps

module tb_rob_core;
    import rob_pkg::*;

    localparam int   SEND_TIMEOUT  = 200;
    localparam int   DRAIN_TIMEOUT = 1000;
    localparam int   SHADOW_LIMIT  = 64;
    localparam logic KIND_COMMIT   = 1'b0;
    localparam logic KIND_REDIRECT = 1'b1;

    logic            clk;
    logic            rst_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] src_a_i;
    logic [XLEN-1:0] src_b_i;
    logic [4:0]      arch_raddr_i;
    logic            stall_o;
    logic            commit_valid_o;
    logic [4:0]      commit_rd_o;
    logic [XLEN-1:0] commit_value_o;
    logic            redirect_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic [XLEN-1:0] arch_rdata_o;

    logic [31:0]     seed;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ref_regs [32];
    string           test_name;

    // expected retirements in program order
    logic            exp_kind [$];
    logic [4:0]      exp_rd   [$];
    rob_result_u     exp_word [$];

    rob_core_top UUT (
        .clk(clk), .rst_i(rst_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .pc_i(pc_i), .src_a_i(src_a_i), .src_b_i(src_b_i), .arch_raddr_i(arch_raddr_i),
        .stall_o(stall_o), .commit_valid_o(commit_valid_o), .commit_rd_o(commit_rd_o),
        .commit_value_o(commit_value_o), .redirect_o(redirect_o),
        .redirect_pc_o(redirect_pc_o), .arch_rdata_o(arch_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // expected word straight from the isa rules
    function automatic rob_result_u ref_result(input op_class_e cls, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
            input logic [XLEN-1:0] at_pc, output logic taken);
        rob_result_u w;
        taken = 1'b0;
        case (cls)
            CLS_LUI: w.value = imm;
            CLS_BEQ: begin
                taken       = (a == b);
                w.target_pc = taken ? at_pc + imm : at_pc + 32'd4;
            end
            default: w.value = a + imm;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] encode(input op_class_e cls, input logic [4:0] rd,
            input logic [XLEN-1:0] imm);
        logic [31:0] w;
        case (cls)
            CLS_LUI: w = {imm[31:12], rd, OPC_LUI};
            // beq x1, x2
            CLS_BEQ: w = {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
            default: w = {imm[11:0], 5'd1, 3'b000, rd, OPC_OP_IMM};
        endcase
        return w;
    endfunction

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input rob_result_u exp, input rob_result_u act);
        if (act.value !== exp.value) begin
            report_fail($sformatf("ERR %s: value expected %h, actual %h", name, exp.value, act.value));
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            report_fail($sformatf("ERR %s: rd expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_target(input string name, input rob_result_u exp,
            input logic [XLEN-1:0] act);
        if (act !== exp.target_pc) begin
            report_fail($sformatf("ERR %s: target expected %h, actual %h", name, exp.target_pc, act));
        end
    endtask

    function automatic void expect_event(input logic kind, input logic [4:0] rd,
            input rob_result_u w);
        exp_kind.push_back(kind);
        exp_rd.push_back(rd);
        exp_word.push_back(w);
    endfunction

    task automatic random_op(output op_class_e cls, output logic [4:0] rd,
            output logic [XLEN-1:0] a, output logic [XLEN-1:0] b, output logic [XLEN-1:0] imm);
        logic [31:0] r;
        r  = next_rand();
        rd = r[10:6];
        a  = next_rand();
        // equal operands now and then, so some branches are taken
        b  = (r[5:4] == 2'b00) ? a : next_rand();
        case (r[1:0])
            2'd2: begin
                cls = CLS_LUI;
                imm = {r[31:12], 12'b0};
            end
            2'd3: begin
                cls = CLS_BEQ;
                imm = {{19{r[31]}}, r[31:20], 1'b0};
            end
            default: begin
                cls = CLS_ADDI;
                imm = {{20{r[31]}}, r[31:20]};
            end
        endcase
    endtask

    // hold one instruction until taken, a shadow one gives up on redirect
    task automatic send(input op_class_e cls, input logic [4:0] rd, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
            input logic [XLEN-1:0] at_pc, input logic shadow, output logic accepted);
        int   waited;
        logic aborted;
        waited        = 0;
        accepted      = 1'b0;
        aborted       = 1'b0;
        instr_valid_i <= 1'b1;
        instr_i       <= encode(cls, rd, imm);
        pc_i          <= at_pc;
        src_a_i       <= a;
        src_b_i       <= b;
        while (!accepted && !aborted) begin
            @(posedge clk);
            if (shadow && redirect_o) begin
                aborted = 1'b1;
            end else if (!stall_o) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited > SEND_TIMEOUT) begin
                    report_fail("timeout: instruction never accepted, stall_o stuck high");
                end
            end
        end
    endtask

    // one program instruction, plus its shadow if it is a taken branch
    task automatic run_one(input op_class_e cls, input logic [4:0] rd, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm);
        rob_result_u     w;
        logic            taken;
        logic            in_shadow;
        int              shadows;
        op_class_e       s_cls;
        logic [4:0]      s_rd;
        logic [XLEN-1:0] s_a;
        logic [XLEN-1:0] s_b;
        logic [XLEN-1:0] s_imm;
        logic [XLEN-1:0] s_pc;
        send(cls, rd, a, b, imm, pc, 1'b0, in_shadow);
        w = ref_result(cls, a, b, imm, pc, taken);
        if (cls != CLS_BEQ && rd != 5'd0) begin
            ref_regs[rd] = w.value;
            expect_event(KIND_COMMIT, rd, w);
        end
        if (cls == CLS_BEQ && taken) begin
            expect_event(KIND_REDIRECT, 5'd0, w);
        end
        s_pc      = pc + 32'd4;
        pc        = (cls == CLS_BEQ) ? w.target_pc : pc + 32'd4;
        in_shadow = taken;
        shadows   = 0;
        // wrong-path traffic until the flush arrives
        while (in_shadow) begin
            random_op(s_cls, s_rd, s_a, s_b, s_imm);
            send(s_cls, s_rd, s_a, s_b, s_imm, s_pc, 1'b1, in_shadow);
            s_pc = s_pc + 32'd4;
            shadows++;
            if (shadows > SHADOW_LIMIT) begin
                report_fail("timeout: redirect_o never came for a taken branch");
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited        = 0;
        instr_valid_i <= 1'b0;
        while (exp_kind.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                report_fail("timeout: expected commits never arrived");
            end
        end
    endtask

    // compare every retirement event against the model
    always @(posedge clk) begin
        rob_result_u act;
        // dispatch holds off while the flush goes out
        if (!rst_i && redirect_o && stall_o !== 1'b1) begin
            report_fail("stall_o was low in the flush cycle of a redirect");
        end
        if (!rst_i && (commit_valid_o || redirect_o)) begin
            if (exp_kind.size() == 0) begin
                report_fail("commit or redirect reported with nothing expected");
            end else if (exp_kind[0] != (redirect_o ? KIND_REDIRECT : KIND_COMMIT)) begin
                report_fail("commit and redirect arrived out of program order");
            end else begin
                if (redirect_o) begin
                    check_target(test_name, exp_word[0], redirect_pc_o);
                end else begin
                    act.value = commit_value_o;
                    check_rd(test_name, exp_rd[0], commit_rd_o);
                    check_value(test_name, exp_word[0], act);
                end
                void'(exp_kind.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_word.pop_front());
            end
        end
    end

    initial begin
        op_class_e       cls;
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [31:0]     rnd;
        rob_result_u     expw;
        rob_result_u     act;
        seed         = 32'h5194;
        pc           = 32'h0000_1000;
        test_name    = "reset";
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        rst_i         <= 1'b1;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        pc_i          <= '0;
        src_a_i       <= '0;
        src_b_i       <= '0;
        arch_raddr_i  <= '0;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);
        if (stall_o !== 1'b0 || commit_valid_o !== 1'b0 || redirect_o !== 1'b0) begin
            report_fail("outputs not idle after reset");
        end

        // fast ops, every fourth one to x0
        test_name = "fast_burst";
        for (int i = 0; i < 12; i++) begin
            rnd = next_rand();
            rd  = (i % 4 == 3) ? 5'd0 : 5'(i + 1);
            if (i % 3 == 2) begin
                run_one(CLS_LUI, rd, next_rand(), '0, {rnd[31:12], 12'b0});
            end else begin
                run_one(CLS_ADDI, rd, next_rand(), '0, {{20{rnd[31]}}, rnd[31:20]});
            end
        end
        drain();

        // slow not-taken branches overtaken by fast ops
        test_name = "interleaved";
        for (int i = 0; i < 16; i++) begin
            rnd = next_rand();
            if (i % 2 == 0) begin
                run_one(CLS_BEQ, 5'd0, rnd, ~rnd, 32'd16);
            end else begin
                run_one(CLS_ADDI, 5'(i), rnd, '0, 32'd3);
            end
        end
        drain();

        // backward taken branch, -64
        test_name = "taken_branch";
        run_one(CLS_ADDI, 5'd5, 32'd10, '0, 32'd1);
        run_one(CLS_BEQ, 5'd0, 32'h55, 32'h55, 32'hFFFF_FFC0);
        run_one(CLS_ADDI, 5'd6, 32'd20, '0, 32'hFFFF_FFFF);
        run_one(CLS_LUI, 5'd7, '0, '0, 32'hABCD_E000);
        drain();

        test_name = "back_to_back";
        for (int i = 0; i < 24; i++) begin
            rnd = next_rand();
            if (i % 4 == 0) begin
                run_one(CLS_BEQ, 5'd0, rnd, rnd + 32'd1, 32'd8);
            end else begin
                run_one(CLS_ADDI, 5'(i), rnd, '0, {{20{rnd[31]}}, rnd[31:20]});
            end
        end
        drain();

        test_name = "random_300";
        for (int i = 0; i < 300; i++) begin
            random_op(cls, rd, a, b, imm);
            run_one(cls, rd, a, b, imm);
        end
        drain();

        // architectural state through the read port
        test_name = "arch_regs";
        for (int i = 0; i < 32; i++) begin
            arch_raddr_i <= 5'(i);
            @(posedge clk);
            act.value  = arch_rdata_o;
            expw.value = ref_regs[i];
            check_value(test_name, expw, act);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
